// File: src/rv_core_consts.svh
`ifndef RV_CORE_CONSTS_SVH
`define RV_CORE_CONSTS_SVH

// Datapath and register file sizing
`define XLEN      32
`define NUM_REGS  16

// First fetch address out of reset
`define RESET_PC  32'h0000_0000

// Major opcodes of the supported subset
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011

`endif

// File: src/rv_core_pkg.sv
`include "rv_core_consts.svh"

package rv_core_pkg;

   // Instruction word views
   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
   } r_fmt_t;

   typedef struct packed {
      logic [11:0] imm;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } i_fmt_t;

   typedef struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
   } s_fmt_t;

   typedef struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
   } b_fmt_t;

   typedef struct packed {
      logic [19:0] imm;
      logic [4:0]  rd;
      logic [6:0]  opcode;
   } u_fmt_t;

   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      s_fmt_t s;
      b_fmt_t b;
      u_fmt_t u;
   } instr_u;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLT,
      ALU_PASS_B   // LUI result is the immediate itself
   } alu_op_e;

   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] pc;
      instr_u           instr;
   } if_id_t;

   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] pc;
      logic [`XLEN-1:0] rs1_val;
      logic [`XLEN-1:0] rs2_val;
      logic [`XLEN-1:0] imm;
      alu_op_e          alu_op;
      logic             use_imm;
      logic [3:0]       rd;
      logic             reg_write;
      logic             is_load;
      logic             is_store;
      logic             is_branch;
      logic             branch_ne;   // BNE when set, BEQ otherwise
   } id_ex_t;

   typedef struct packed {
      logic             valid;
      logic [`XLEN-1:0] result;      // Also the load/store address
      logic [`XLEN-1:0] store_data;
      logic [3:0]       rd;
      logic             reg_write;
      logic             is_load;
      logic             is_store;
   } ex_mem_t;

   typedef struct packed {
      logic             we;
      logic [3:0]       rd;
      logic [`XLEN-1:0] data;
   } wb_t;

endpackage

// File: src/fetch_stage.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module fetch_stage (
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic                stall_i,
   input  logic                branch_taken_i,
   input  logic [`XLEN-1:0]    branch_target_i,
   output logic [`XLEN-1:0]    instr_addr_o,
   input  logic [31:0]         instr_data_i,
   output rv_core_pkg::if_id_t if_id_o
);
   import rv_core_pkg::*;

   logic [`XLEN-1:0] pc_q;
   if_id_t           if_id_q;

   assign instr_addr_o = pc_q;   // Instruction port answers in the same cycle
   assign if_id_o      = if_id_q;

   // A redirect wins over any stall. While memory is stalled the branch stays
   // in execute and simply redirects to the same target again
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         pc_q    <= `RESET_PC;
         if_id_q <= '0;
      end else if (branch_taken_i) begin
         pc_q          <= branch_target_i;
         if_id_q.valid <= 1'b0;   // Kill the wrong-path fetch
      end else if (!stall_i) begin
         pc_q          <= pc_q + `XLEN'd4;
         if_id_q.valid <= 1'b1;
         if_id_q.pc    <= pc_q;
         if_id_q.instr <= instr_data_i;
      end
   end

   // Branch targets come from execute, so alignment depends on decode's B immediate
   a_pc_aligned: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      pc_q[1:0] == 2'b00);

endmodule

// File: src/decode_stage.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module decode_stage (
   input  logic                 clk_i,
   input  logic                 rst_n_i,
   input  rv_core_pkg::if_id_t  if_id_i,
   input  logic                 mem_stall_i,
   input  logic                 flush_i,
   input  logic [3:0]           ex_rd_i,
   input  logic                 ex_wr_i,
   input  rv_core_pkg::wb_t     wb_i,
   output logic                 hazard_stall_o,
   output rv_core_pkg::id_ex_t  id_ex_o
);
   import rv_core_pkg::*;

   instr_u           instr;
   logic [3:0]       rs1_a;
   logic [3:0]       rs2_a;
   logic [3:0]       rd_a;
   logic             uses_rs1;
   logic             uses_rs2;
   logic             issue;
   logic [`XLEN-1:0] regs [`NUM_REGS];
   id_ex_t           id_ex_d;
   id_ex_t           id_ex_q;

   // x0 reads zero and a same-cycle writeback is seen through
   function automatic logic [`XLEN-1:0] read_reg(input logic [3:0] addr);
      if (addr == 4'd0)
         return '0;
      if (wb_i.we && wb_i.rd == addr)
         return wb_i.data;
      return regs[addr];
   endfunction

   // Source is still owed by the instruction in execute or memory
   function automatic logic pending(input logic [3:0] addr);
      return (addr != 4'd0) &&
             ((id_ex_q.reg_write && id_ex_q.rd == addr) || (ex_wr_i && ex_rd_i == addr));
   endfunction

   assign instr   = if_id_i.instr;
   assign rs1_a   = instr.r.rs1[3:0];   // RV32E has only 16 registers
   assign rs2_a   = instr.r.rs2[3:0];
   assign rd_a    = instr.r.rd[3:0];
   assign id_ex_o = id_ex_q;

   always_comb begin
      id_ex_d         = '0;
      id_ex_d.pc      = if_id_i.pc;
      id_ex_d.rs1_val = read_reg(rs1_a);
      id_ex_d.rs2_val = read_reg(rs2_a);
      id_ex_d.rd      = rd_a;
      id_ex_d.alu_op  = ALU_ADD;
      uses_rs1        = 1'b1;
      uses_rs2        = 1'b0;
      case (instr.r.opcode)
         `OPC_OP: begin
            uses_rs2          = 1'b1;
            id_ex_d.reg_write = 1'b1;
            case (instr.r.funct3)
               3'b000:  id_ex_d.alu_op = instr.r.funct7[5] ? ALU_SUB : ALU_ADD;
               3'b010:  id_ex_d.alu_op = ALU_SLT;
               3'b100:  id_ex_d.alu_op = ALU_XOR;
               3'b110:  id_ex_d.alu_op = ALU_OR;
               3'b111:  id_ex_d.alu_op = ALU_AND;
               default: id_ex_d.alu_op = ALU_ADD;
            endcase
         end
         `OPC_OP_IMM: begin   // ADDI only
            id_ex_d.use_imm   = 1'b1;
            id_ex_d.reg_write = 1'b1;
            id_ex_d.imm       = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
         end
         `OPC_LUI: begin
            uses_rs1          = 1'b0;
            id_ex_d.alu_op    = ALU_PASS_B;
            id_ex_d.use_imm   = 1'b1;
            id_ex_d.reg_write = 1'b1;
            id_ex_d.imm       = {instr.u.imm, 12'b0};
         end
         `OPC_LOAD: begin
            id_ex_d.use_imm   = 1'b1;
            id_ex_d.reg_write = 1'b1;
            id_ex_d.is_load   = 1'b1;
            id_ex_d.imm       = {{(`XLEN-12){instr.i.imm[11]}}, instr.i.imm};
         end
         `OPC_STORE: begin
            uses_rs2         = 1'b1;
            id_ex_d.use_imm  = 1'b1;
            id_ex_d.is_store = 1'b1;
            id_ex_d.imm      = {{(`XLEN-12){instr.s.imm_hi[6]}}, instr.s.imm_hi,
                                instr.s.imm_lo};
         end
         `OPC_BRANCH: begin
            uses_rs2          = 1'b1;
            id_ex_d.is_branch = 1'b1;
            id_ex_d.branch_ne = instr.b.funct3[0];
            id_ex_d.imm       = {{(`XLEN-12){instr.b.imm12}}, instr.b.imm11,
                                 instr.b.imm10_5, instr.b.imm4_1, 1'b0};
         end
         default: uses_rs1 = 1'b0;   // Unsupported opcodes retire as NOPs
      endcase
      if (rd_a == 4'd0)
         id_ex_d.reg_write = 1'b0;
   end

   always_comb begin
      hazard_stall_o = if_id_i.valid &&
                       ((uses_rs1 && pending(rs1_a)) || (uses_rs2 && pending(rs2_a)));
   end

   assign issue = if_id_i.valid && !flush_i && !hazard_stall_o;

   // Bubble on flush or interlock and full freeze on a data port stall
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         id_ex_q <= '0;
      end else if (!mem_stall_i) begin
         id_ex_q           <= id_ex_d;
         id_ex_q.valid     <= issue;
         id_ex_q.reg_write <= issue && id_ex_d.reg_write;
      end
   end

   always_ff @(posedge clk_i) begin
      if (wb_i.we) begin
         regs[wb_i.rd] <= wb_i.data;
      end
   end

   // Writeback comes from the memory stage; x0 filtering must survive the whole pipe
   a_no_x0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      wb_i.we |-> wb_i.rd != 4'd0);

endmodule

// File: src/execute_stage.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module execute_stage (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  rv_core_pkg::id_ex_t   id_ex_i,
   input  logic                  mem_stall_i,
   output logic                  branch_taken_o,
   output logic [`XLEN-1:0]      branch_target_o,
   output rv_core_pkg::ex_mem_t  ex_mem_o
);
   import rv_core_pkg::*;

   logic [`XLEN-1:0] op_b;
   logic [`XLEN-1:0] alu_res;
   logic             rs_equal;
   ex_mem_t          ex_mem_q;

   assign op_b = id_ex_i.use_imm ? id_ex_i.imm : id_ex_i.rs2_val;

   always_comb begin
      case (id_ex_i.alu_op)
         ALU_ADD:    alu_res = id_ex_i.rs1_val + op_b;
         ALU_SUB:    alu_res = id_ex_i.rs1_val - op_b;
         ALU_AND:    alu_res = id_ex_i.rs1_val & op_b;
         ALU_OR:     alu_res = id_ex_i.rs1_val | op_b;
         ALU_XOR:    alu_res = id_ex_i.rs1_val ^ op_b;
         ALU_SLT:    alu_res = {{(`XLEN-1){1'b0}}, $signed(id_ex_i.rs1_val) < $signed(op_b)};
         ALU_PASS_B: alu_res = op_b;
         default:    alu_res = '0;
      endcase
   end

   // Branch resolution, always against rs2 and never the immediate
   assign rs_equal        = (id_ex_i.rs1_val == id_ex_i.rs2_val);
   assign branch_taken_o  = id_ex_i.valid && id_ex_i.is_branch &&
                            (rs_equal != id_ex_i.branch_ne);
   assign branch_target_o = id_ex_i.pc + id_ex_i.imm;

   assign ex_mem_o = ex_mem_q;

   // Control bits carry the valid bit so decode can use reg_write directly
   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ex_mem_q <= '0;
      end else if (!mem_stall_i) begin
         ex_mem_q.valid      <= id_ex_i.valid;
         ex_mem_q.result     <= alu_res;
         ex_mem_q.store_data <= id_ex_i.rs2_val;
         ex_mem_q.rd         <= id_ex_i.rd;
         ex_mem_q.reg_write  <= id_ex_i.valid && id_ex_i.reg_write;
         ex_mem_q.is_load    <= id_ex_i.valid && id_ex_i.is_load;
         ex_mem_q.is_store   <= id_ex_i.valid && id_ex_i.is_store;
      end
   end

   // Decode must turn the shadow of a taken branch into a bubble
   a_branch_shadow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      branch_taken_o && !mem_stall_i |=> !id_ex_i.valid);

endmodule

// File: src/memory_stage.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module memory_stage (
   input  logic                  clk_i,
   input  logic                  rst_n_i,
   input  rv_core_pkg::ex_mem_t  ex_mem_i,
   output logic                  data_req_o,
   output logic                  data_we_o,
   output logic [`XLEN-1:0]      data_addr_o,
   output logic [`XLEN-1:0]      data_wdata_o,
   input  logic [`XLEN-1:0]      data_rdata_i,
   input  logic                  data_ready_i,
   output logic                  mem_stall_o,
   output rv_core_pkg::wb_t      wb_o
);

   // Request lives as long as the entry sits in EX/MEM
   assign data_req_o   = ex_mem_i.valid && (ex_mem_i.is_load || ex_mem_i.is_store);
   assign data_we_o    = ex_mem_i.is_store;
   assign data_addr_o  = ex_mem_i.result;
   assign data_wdata_o = ex_mem_i.store_data;

   assign mem_stall_o = data_req_o && !data_ready_i;   // Freezes the whole pipe

   // Register write on the edge that ends the memory cycle
   always_comb begin
      wb_o.we   = ex_mem_i.valid && ex_mem_i.reg_write && !mem_stall_o;
      wb_o.rd   = ex_mem_i.rd;
      wb_o.data = ex_mem_i.is_load ? data_rdata_i : ex_mem_i.result;   // Load data taken on ready
   end

   // Held request relies on every upstream register freezing together
   a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      data_req_o && !data_ready_i |=>
         data_req_o && $stable(data_addr_o) && $stable(data_we_o) && $stable(data_wdata_o));

endmodule

// File: src/rv_core.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module rv_core (
   input  logic             clk_i,
   input  logic             rst_n_i,
   output logic [`XLEN-1:0] instr_addr_o,
   input  logic [31:0]      instr_data_i,
   output logic             data_req_o,
   output logic             data_we_o,
   output logic [`XLEN-1:0] data_addr_o,
   output logic [`XLEN-1:0] data_wdata_o,
   input  logic [`XLEN-1:0] data_rdata_i,
   input  logic             data_ready_i
);
   import rv_core_pkg::*;

   if_id_t           if_id;
   id_ex_t           id_ex;
   ex_mem_t          ex_mem;
   wb_t              wb;
   logic             branch_taken;
   logic [`XLEN-1:0] branch_target;
   logic             mem_stall;
   logic             hazard_stall;
   logic             fetch_stall;

   assign fetch_stall = mem_stall | hazard_stall;   // Fetch holds for either cause

   fetch_stage u_fetch (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .stall_i         (fetch_stall),
      .branch_taken_i  (branch_taken),
      .branch_target_i (branch_target),
      .instr_addr_o    (instr_addr_o),
      .instr_data_i    (instr_data_i),
      .if_id_o         (if_id)
   );

   decode_stage u_decode (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .if_id_i        (if_id),
      .mem_stall_i    (mem_stall),
      .flush_i        (branch_taken),
      .ex_rd_i        (ex_mem.rd),          // Instruction now in memory
      .ex_wr_i        (ex_mem.reg_write),
      .wb_i           (wb),
      .hazard_stall_o (hazard_stall),
      .id_ex_o        (id_ex)
   );

   execute_stage u_execute (
      .clk_i           (clk_i),
      .rst_n_i         (rst_n_i),
      .id_ex_i         (id_ex),
      .mem_stall_i     (mem_stall),
      .branch_taken_o  (branch_taken),
      .branch_target_o (branch_target),
      .ex_mem_o        (ex_mem)
   );

   memory_stage u_memory (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .ex_mem_i     (ex_mem),
      .data_req_o   (data_req_o),
      .data_we_o    (data_we_o),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .data_rdata_i (data_rdata_i),
      .data_ready_i (data_ready_i),
      .mem_stall_o  (mem_stall),
      .wb_o         (wb)
   );

endmodule

// File: verification/tb_rv_core.sv
`timescale 1ns/10ps
`include "rv_core_consts.svh"

module tb_rv_core;

   localparam int CLK_PERIOD  = 4;
   localparam int BODY_START  = 15;   // Prologue writes x1..x15
   localparam int BODY_LEN    = 160;
   localparam int BODY_END    = BODY_START + BODY_LEN;
   localparam int PROG_LEN    = BODY_END + 16;   // Register dump and halt
   localparam int HALT_IDX    = PROG_LEN - 1;
   localparam int MAX_CPI     = 24;
   localparam int WATCHDOG_NS = (PROG_LEN * MAX_CPI + 60) * CLK_PERIOD;
   localparam logic [31:0] SEED = 32'hd50982fa;
   localparam logic [31:0] NOP  = 32'h0000_0013;

   localparam int K_ADD  = 0;
   localparam int K_SUB  = 1;
   localparam int K_AND  = 2;
   localparam int K_OR   = 3;
   localparam int K_XOR  = 4;
   localparam int K_SLT  = 5;
   localparam int K_ADDI = 6;
   localparam int K_LUI  = 7;
   localparam int K_LW   = 8;
   localparam int K_SW   = 9;
   localparam int K_BEQ  = 10;
   localparam int K_BNE  = 11;

   logic             clk_i;
   logic             rst_n_i;
   logic [`XLEN-1:0] instr_addr_o;
   logic [31:0]      instr_data_i;
   logic             data_req_o;
   logic             data_we_o;
   logic [`XLEN-1:0] data_addr_o;
   logic [`XLEN-1:0] data_wdata_o;
   logic [`XLEN-1:0] data_rdata_i;
   logic             data_ready_i;

   logic [31:0] lfsr_state;
   logic [31:0] imem [PROG_LEN];
   int          kind_a [PROG_LEN];
   int          rd_a [PROG_LEN];
   int          rs1_a [PROG_LEN];
   int          rs2_a [PROG_LEN];
   int          imm_a [PROG_LEN];
   int          prog_len;
   logic [31:0] dmem_dut [128];
   logic [31:0] dmem_model [128];
   logic [31:0] regs_model [`NUM_REGS];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   int          exp_count;
   int          dut_stores;
   int          errors;
   logic        req_waiting;
   logic [31:0] held_addr;
   logic        held_we;
   logic [31:0] held_wdata;

   rv_core u_rv_core (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .instr_addr_o (instr_addr_o),
      .instr_data_i (instr_data_i),
      .data_req_o   (data_req_o),
      .data_we_o    (data_we_o),
      .data_addr_o  (data_addr_o),
      .data_wdata_o (data_wdata_o),
      .data_rdata_i (data_rdata_i),
      .data_ready_i (data_ready_i)
   );

   // Both memories answer in the same cycle
   assign instr_data_i = (instr_addr_o[31:2] < PROG_LEN) ? imem[instr_addr_o[31:2]] : NOP;
   assign data_rdata_i = dmem_dut[data_addr_o[8:2]];

   initial begin
      clk_i = 1'b0;
      forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      int          b;
      v = '0;
      for (b = 0; b < n; b++) begin
         lfsr_state = lfsr_next(lfsr_state);
         v          = {v[30:0], lfsr_state[0]};
      end
      return v;
   endfunction

   function automatic int pick_reg();
      int r;
      r = rand_bits(4);
      return (r == 0) ? 15 : r;   // Never x0 as a destination
   endfunction

   function automatic int rand_imm12();
      int v;
      v = rand_bits(12);
      return (v >= 2048) ? v - 4096 : v;
   endfunction

   // Instruction word from the RV32I encoding tables
   function automatic logic [31:0] encode(input int k, input int rd, input int rs1,
                                          input int rs2, input int imm);
      logic [31:0] iw;
      logic [4:0]  d;
      logic [4:0]  a;
      logic [4:0]  b;
      iw = imm;
      d  = rd[4:0];
      a  = rs1[4:0];
      b  = rs2[4:0];
      case (k)
         K_ADD:   return {7'b0000000, b, a, 3'b000, d, `OPC_OP};
         K_SUB:   return {7'b0100000, b, a, 3'b000, d, `OPC_OP};
         K_AND:   return {7'b0000000, b, a, 3'b111, d, `OPC_OP};
         K_OR:    return {7'b0000000, b, a, 3'b110, d, `OPC_OP};
         K_XOR:   return {7'b0000000, b, a, 3'b100, d, `OPC_OP};
         K_SLT:   return {7'b0000000, b, a, 3'b010, d, `OPC_OP};
         K_ADDI:  return {iw[11:0], a, 3'b000, d, `OPC_OP_IMM};
         K_LUI:   return {iw[19:0], d, `OPC_LUI};
         K_LW:    return {iw[11:0], a, 3'b010, d, `OPC_LOAD};
         K_SW:    return {iw[11:5], b, a, 3'b010, iw[4:0], `OPC_STORE};
         K_BEQ:   return {iw[12], iw[10:5], b, a, 3'b000, iw[4:1], iw[11], `OPC_BRANCH};
         K_BNE:   return {iw[12], iw[10:5], b, a, 3'b001, iw[4:1], iw[11], `OPC_BRANCH};
         default: return NOP;
      endcase
   endfunction

   task automatic emit(input int k, input int rd, input int rs1, input int rs2, input int imm);
      kind_a[prog_len] = k;
      rd_a[prog_len]   = rd;
      rs1_a[prog_len]  = rs1;
      rs2_a[prog_len]  = rs2;
      imm_a[prog_len]  = imm;
      imem[prog_len]   = encode(k, rd, rs1, rs2, imm);
      prog_len++;
   endtask

   task automatic build_program();
      int sel;
      int op;
      int rd;
      int rs1;
      int rs2;
      int imm;
      int skip;
      int last_rd;
      prog_len = 0;
      for (rd = 1; rd < 16; rd++) begin
         imm = rand_imm12();
         emit(K_ADDI, rd, 0, 0, imm);
      end
      last_rd = 15;
      while (prog_len < BODY_END) begin
         sel = rand_bits(4);
         rd  = pick_reg();
         rs1 = rand_bits(1) ? last_rd : pick_reg();   // Back-to-back dependency
         rs2 = pick_reg();
         op  = rand_bits(3) % 6;
         imm = rand_imm12();
         if (sel < 6) begin
            emit(op, rd, rs1, rs2, 0);
         end else if (sel < 9) begin
            emit(K_ADDI, rd, rs1, 0, imm);
         end else if (sel == 9) begin
            imm = rand_bits(20);
            emit(K_LUI, rd, 0, 0, imm);
         end else if (sel < 12 && prog_len < BODY_END - 1) begin
            imm = 4 * rand_bits(6);
            emit(K_LW, rd, 0, 0, imm);
            rs1 = rd;
            rd  = pick_reg();
            emit(op, rd, rs1, rs2, 0);   // Load result used at once
         end else if (sel < 14) begin
            imm = 4 * rand_bits(6);
            emit(K_SW, 0, 0, rs1, imm);
            rd = last_rd;
         end else begin
            skip = 1 + rand_bits(2) % 3;
            if (skip > BODY_END - 1 - prog_len)
               skip = BODY_END - 1 - prog_len;
            if (rand_bits(1))
               rs2 = rs1;   // Equal operands so BEQ gets taken too
            if (skip < 1) begin
               emit(K_ADDI, rd, rs1, 0, imm);
            end else begin
               op = rand_bits(1) ? K_BNE : K_BEQ;
               emit(op, 0, rs1, rs2, 4 * (skip + 1));
               rd = last_rd;
            end
         end
         last_rd = rd;
      end
      for (rd = 1; rd < 16; rd++)
         emit(K_SW, 0, 0, rd, 256 + 4 * rd);
      emit(K_BEQ, 0, 0, 0, 0);   // Spins on itself
   endtask

   task automatic fill_memories();
      int i;
      for (i = 0; i < 128; i++) begin
         dmem_dut[i]   = rand_bits(32);
         dmem_model[i] = dmem_dut[i];
      end
   endtask

   // Architectural model, one instruction per step
   task automatic run_model();
      int          pc;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] addr;
      regs_model[0] = '0;
      pc = 0;
      while (pc != HALT_IDX) begin
         a    = regs_model[rs1_a[pc]];
         b    = regs_model[rs2_a[pc]];
         addr = a + imm_a[pc];
         case (kind_a[pc])
            K_ADD:  regs_model[rd_a[pc]] = a + b;
            K_SUB:  regs_model[rd_a[pc]] = a - b;
            K_AND:  regs_model[rd_a[pc]] = a & b;
            K_OR:   regs_model[rd_a[pc]] = a | b;
            K_XOR:  regs_model[rd_a[pc]] = a ^ b;
            K_SLT:  regs_model[rd_a[pc]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            K_ADDI: regs_model[rd_a[pc]] = a + imm_a[pc];
            K_LUI:  regs_model[rd_a[pc]] = imm_a[pc] << 12;
            K_LW:   regs_model[rd_a[pc]] = dmem_model[addr[8:2]];
            K_SW: begin
               dmem_model[addr[8:2]] = b;
               exp_addr.push_back(addr);
               exp_data.push_back(b);
            end
            default: ;
         endcase
         if ((kind_a[pc] == K_BEQ && a == b) || (kind_a[pc] == K_BNE && a != b))
            pc = pc + imm_a[pc] / 4;
         else
            pc = pc + 1;
      end
      exp_count = exp_addr.size();
   endtask

   task automatic check_store();
      logic [31:0] ea;
      logic [31:0] ed;
      dut_stores++;
      dmem_dut[data_addr_o[8:2]] = data_wdata_o;
      if (exp_addr.size() == 0) begin
         errors++;
         $display("Store #%0d to %h has no matching store in the model", dut_stores,
                  data_addr_o);
      end else begin
         ea = exp_addr.pop_front();
         ed = exp_data.pop_front();
         if (data_addr_o !== ea) begin
            errors++;
            $display("[FAIL] store_addr #%0d: expected %h, actual %h", dut_stores, ea,
                     data_addr_o);
         end
         if (data_wdata_o !== ed) begin
            errors++;
            $display("[FAIL] store_data #%0d: expected %h, actual %h", dut_stores, ed,
                     data_wdata_o);
         end
      end
   endtask

   // Ready low on roughly five draws out of sixteen
   always @(posedge clk_i) begin
      if (rst_n_i)
         data_ready_i <= (rand_bits(4) >= 5);
   end

   // Port monitor sampled mid-cycle
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         if (data_req_o !== 1'b0) begin
            errors++;
            $display("data_req_o was not low during reset at %0t", $time);
         end
      end else begin
         if (req_waiting && (data_req_o !== 1'b1 || data_addr_o !== held_addr ||
                             data_we_o !== held_we || data_wdata_o !== held_wdata)) begin
            errors++;
            $display("A waiting data request changed or was dropped at %0t", $time);
         end
         if (data_req_o && data_ready_i && data_we_o)
            check_store();
         req_waiting = data_req_o && !data_ready_i;
         held_addr   = data_addr_o;
         held_we     = data_we_o;
         held_wdata  = data_wdata_o;
      end
   end

   initial begin
      #(WATCHDOG_NS);
      $display("Watchdog expired after %0d ns, the core never finished its program",
               WATCHDOG_NS);
      $display("Test failed");
      $finish;
   end

   initial begin
      rst_n_i      = 1'b0;
      data_ready_i = 1'b0;
      req_waiting  = 1'b0;
      dut_stores   = 0;
      errors       = 0;
      lfsr_state   = SEED;
      fill_memories();
      build_program();
      run_model();

      repeat (10) @(posedge clk_i);
      rst_n_i <= 1'b1;
      @(negedge clk_i);
      if (instr_addr_o !== `RESET_PC) begin
         errors++;
         $display("[FAIL] reset_pc: expected %h, actual %h", `RESET_PC, instr_addr_o);
      end

      while (instr_addr_o != HALT_IDX * 4)
         @(negedge clk_i);
      while (dut_stores < exp_count)   // Dump stores may still be draining
         @(negedge clk_i);
      repeat (20) @(negedge clk_i);
      if (dut_stores != exp_count) begin
         errors++;
         $display("[FAIL] store_count: expected %0d, actual %0d", exp_count, dut_stores);
      end

      $display("Stores: %0d of %0d, errors: %0d", dut_stores, exp_count, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

// File: rv_core.f
+incdir+src
src/rv_core_pkg.sv
src/fetch_stage.sv
src/decode_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/rv_core.sv
verification/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - include_dirs:
      - src
    files:
      - src/rv_core_pkg.sv
      - src/fetch_stage.sv
      - src/decode_stage.sv
      - src/execute_stage.sv
      - src/memory_stage.sv
      - src/rv_core.sv
  - target: test
    include_dirs:
      - src
    files:
      - verification/tb_rv_core.sv
